// ==== verilog/code_geometry_pkg.sv ====
// shape and sizing of the planar patch decoded by the union-find grid
// modules refer to these by scoped name, e.g. code_geometry_pkg::pu_count
package code_geometry_pkg;

    // one unit per Z-type stabilizer; columns run along the X distance
    localparam int grid_cols = 4;  // code distance X minus one
    localparam int grid_rows = 4;  // code distance Z

    localparam int pu_count = grid_cols * grid_rows;

    // a unit index is row * grid_cols + column, and roots use the same encoding
    localparam int address_width = 4;

    // growth counters per edge
    localparam int growth_width = 2;

    // uniform weight, all inner and boundary edges fill after this many steps
    localparam logic [growth_width-1:0] edge_weight = 2'd2;

    // growth iterations allowed before the round is flagged as deadlocked
    localparam int max_iterations = 16;

endpackage

// ==== verilog/decoder_stage_pkg.sv ====
// stage encoding shared by the stage controller and the decoding grid
package decoder_stage_pkg;

    // one round walks idle -> load -> check -> (grow -> merge -> check)* -> result
    typedef enum logic [2:0] {
        stage_idle   = 3'd0,
        stage_load   = 3'd1,
        stage_grow   = 3'd2,
        stage_merge  = 3'd3,
        stage_check  = 3'd4,
        stage_result = 3'd5
    } stage_t;

    // wide enough for max_iterations with headroom
    localparam int iteration_width = 8;

endpackage

// ==== verilog/processing_unit.sv ====
// one syndrome node of the grid: holds its defect bit and its cluster root
// and pulls in the smallest root across fully grown edges during merge
`timescale 1ns/1ps

module processing_unit #(
    parameter logic [code_geometry_pkg::address_width-1:0] unit_index = '0
) (
    input  logic                                               clk,
    input  logic                                               rst,
    input  decoder_stage_pkg::stage_t                          stage,
    input  logic                                               is_error_syndrome,
    // order is left, right, up, down
    input  logic [3:0][code_geometry_pkg::address_width-1:0]   neighbor_roots,
    input  logic [3:0]                                         neighbor_grown,
    output logic [code_geometry_pkg::address_width-1:0]        root,
    output logic                                               is_defect,
    output logic                                               root_changed
);

    logic [code_geometry_pkg::address_width-1:0] min_root;

    always_comb begin
        min_root = root;
        for (int d = 0; d < 4; d++) begin
            if (neighbor_grown[d] && (neighbor_roots[d] < min_root)) begin
                min_root = neighbor_roots[d];
            end
        end
    end

    // only meaningful while merging, the grid ORs these into has_message_flying
    assign root_changed = (stage == decoder_stage_pkg::stage_merge) && (min_root != root);

    always_ff @(posedge clk) begin
        if (rst) begin
            root      <= unit_index;
            is_defect <= 1'b0;
        end else begin
            case (stage)
                decoder_stage_pkg::stage_load: begin
                    root      <= unit_index;  // every unit starts as its own cluster
                    is_defect <= is_error_syndrome;
                end
                decoder_stage_pkg::stage_merge: begin
                    root <= min_root;
                end
                default: begin
                    root <= root;
                end
            endcase
        end
    end

endmodule

// ==== verilog/edge_tracker.sv ====
// growth counter of one edge, fed by the odd flags of the units at its ends
// a boundary edge ties grow_b low
`timescale 1ns/1ps

module edge_tracker (
    input  logic                      clk,
    input  logic                      rst,
    input  decoder_stage_pkg::stage_t stage,
    input  logic                      grow_a,
    input  logic                      grow_b,
    output logic                      grown
);

    logic [code_geometry_pkg::growth_width-1:0] count;
    logic [code_geometry_pkg::growth_width:0]   sum;  // one spare bit before saturation

    assign sum = {1'b0, count}
               + {{code_geometry_pkg::growth_width{1'b0}}, grow_a}
               + {{code_geometry_pkg::growth_width{1'b0}}, grow_b};

    always_ff @(posedge clk) begin
        if (rst || (stage == decoder_stage_pkg::stage_load)) begin
            count <= '0;
        end else if (stage == decoder_stage_pkg::stage_grow) begin
            if (sum >= {1'b0, code_geometry_pkg::edge_weight}) begin
                count <= code_geometry_pkg::edge_weight;
            end else begin
                count <= sum[code_geometry_pkg::growth_width-1:0];
            end
        end
    end

    assign grown = (count == code_geometry_pkg::edge_weight);

endmodule

// ==== verilog/cluster_tracker.sv ====
// combinational cluster bookkeeping: a unit is odd when its cluster holds
// an odd number of defects and no member touches a grown boundary edge
`timescale 1ns/1ps

module cluster_tracker (
    input  logic [code_geometry_pkg::pu_count*code_geometry_pkg::address_width-1:0] roots,
    input  logic [code_geometry_pkg::pu_count-1:0]                                  is_defects,
    input  logic [code_geometry_pkg::pu_count-1:0]                                  boundary_grown,
    output logic [code_geometry_pkg::pu_count-1:0]                                  is_odd_clusters
);

    localparam int aw = code_geometry_pkg::address_width;

    always_comb begin
        logic parity;
        logic touching;
        logic [aw-1:0] own_root;
        for (int i = 0; i < code_geometry_pkg::pu_count; i++) begin
            parity   = 1'b0;
            touching = 1'b0;
            own_root = roots[i*aw +: aw];
            // every member of the cluster sees the same totals
            for (int j = 0; j < code_geometry_pkg::pu_count; j++) begin
                if (roots[j*aw +: aw] == own_root) begin
                    parity   = parity ^ is_defects[j];
                    touching = touching | boundary_grown[j];
                end
            end
            is_odd_clusters[i] = parity & ~touching;
        end
    end

endmodule

// ==== verilog/decoding_grid.sv ====
// array of processing units with their inner and boundary edges
// reports root activity during merge and a registered odd-cluster flag
`timescale 1ns/1ps

module decoding_grid (
    input  logic                                                                    clk,
    input  logic                                                                    rst,
    input  decoder_stage_pkg::stage_t                                               stage,
    input  logic [code_geometry_pkg::pu_count-1:0]                                  is_error_syndromes,
    output logic [code_geometry_pkg::pu_count*code_geometry_pkg::address_width-1:0] roots,
    output logic                                                                    has_message_flying,
    output logic                                                                    has_odd_clusters
);

    localparam int aw = code_geometry_pkg::address_width;
    localparam int cols = code_geometry_pkg::grid_cols;
    localparam int rows = code_geometry_pkg::grid_rows;
    localparam int n = code_geometry_pkg::pu_count;

    logic [n-1:0] is_defects;
    logic [n-1:0] root_changed;
    logic [n-1:0] is_odd_clusters;
    logic [n-1:0] right_grown;     // edge to the unit at column + 1
    logic [n-1:0] down_grown;      // edge to the unit at row + 1
    logic [n-1:0] boundary_grown;

    for (genvar r = 0; r < rows; r++) begin : g_row
        for (genvar c = 0; c < cols; c++) begin : g_col
            localparam int unit = r * cols + c;

            logic [3:0][aw-1:0] nbr_roots;
            logic [3:0]         nbr_grown;

            if (c > 0) begin : g_left
                assign nbr_roots[0] = roots[(unit-1)*aw +: aw];
                assign nbr_grown[0] = right_grown[unit-1];
            end else begin : g_no_left
                assign nbr_roots[0] = '0;
                assign nbr_grown[0] = 1'b0;
            end

            if (c < cols - 1) begin : g_right
                edge_tracker u_edge_right (
                    .clk(clk), .rst(rst), .stage(stage),
                    .grow_a(is_odd_clusters[unit]),
                    .grow_b(is_odd_clusters[unit+1]),
                    .grown(right_grown[unit])
                );
                assign nbr_roots[1] = roots[(unit+1)*aw +: aw];
                assign nbr_grown[1] = right_grown[unit];
            end else begin : g_no_right
                assign right_grown[unit] = 1'b0;
                assign nbr_roots[1] = '0;
                assign nbr_grown[1] = 1'b0;
            end

            if (r > 0) begin : g_up
                assign nbr_roots[2] = roots[(unit-cols)*aw +: aw];
                assign nbr_grown[2] = down_grown[unit-cols];
            end else begin : g_no_up
                assign nbr_roots[2] = '0;
                assign nbr_grown[2] = 1'b0;
            end

            if (r < rows - 1) begin : g_down
                edge_tracker u_edge_down (
                    .clk(clk), .rst(rst), .stage(stage),
                    .grow_a(is_odd_clusters[unit]),
                    .grow_b(is_odd_clusters[unit+cols]),
                    .grown(down_grown[unit])
                );
                assign nbr_roots[3] = roots[(unit+cols)*aw +: aw];
                assign nbr_grown[3] = down_grown[unit];
            end else begin : g_no_down
                assign down_grown[unit] = 1'b0;
                assign nbr_roots[3] = '0;
                assign nbr_grown[3] = 1'b0;
            end

            // left and right columns sit next to the code boundary
            if ((c == 0) || (c == cols - 1)) begin : g_boundary
                edge_tracker u_edge_boundary (
                    .clk(clk), .rst(rst), .stage(stage),
                    .grow_a(is_odd_clusters[unit]),
                    .grow_b(1'b0),
                    .grown(boundary_grown[unit])
                );
            end else begin : g_inner
                assign boundary_grown[unit] = 1'b0;
            end

            processing_unit #(
                .unit_index(unit[aw-1:0])
            ) u_processing_unit (
                .clk(clk),
                .rst(rst),
                .stage(stage),
                .is_error_syndrome(is_error_syndromes[unit]),
                .neighbor_roots(nbr_roots),
                .neighbor_grown(nbr_grown),
                .root(roots[unit*aw +: aw]),
                .is_defect(is_defects[unit]),
                .root_changed(root_changed[unit])
            );
        end
    end

    cluster_tracker u_cluster_tracker (
        .roots(roots),
        .is_defects(is_defects),
        .boundary_grown(boundary_grown),
        .is_odd_clusters(is_odd_clusters)
    );

    assign has_message_flying = |root_changed;

    always_ff @(posedge clk) begin
        if (rst) begin
            has_odd_clusters <= 1'b0;
        end else begin
            has_odd_clusters <= |is_odd_clusters;  // settles on the second check cycle
        end
    end

endmodule

// ==== verilog/decoder_stage_controller.sv ====
// stage FSM of the decoder: steps the grid through load, check, grow and merge
// and keeps iteration and cycle counts plus the held result flags
`timescale 1ns/1ps

module decoder_stage_controller (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          new_round_start,
    input  logic                                          has_message_flying,
    input  logic                                          has_odd_clusters,
    output decoder_stage_pkg::stage_t                     stage,
    output logic                                          result_valid,
    output logic [decoder_stage_pkg::iteration_width-1:0] iteration_counter,
    output logic [31:0]                                   cycle_counter,
    output logic                                          deadlock
);

    localparam logic [decoder_stage_pkg::iteration_width-1:0] iteration_limit =
        code_geometry_pkg::max_iterations[decoder_stage_pkg::iteration_width-1:0];

    logic check_second;  // second check cycle, has_odd_clusters is valid here

    always_ff @(posedge clk) begin
        if (rst) begin
            stage             <= decoder_stage_pkg::stage_idle;
            check_second      <= 1'b0;
            result_valid      <= 1'b0;
            deadlock          <= 1'b0;
            iteration_counter <= '0;
            cycle_counter     <= '0;
        end else begin
            if ((stage != decoder_stage_pkg::stage_idle) &&
                (stage != decoder_stage_pkg::stage_result)) begin
                cycle_counter <= cycle_counter + 32'd1;
            end
            case (stage)
                decoder_stage_pkg::stage_idle, decoder_stage_pkg::stage_result: begin
                    if (new_round_start) begin
                        stage             <= decoder_stage_pkg::stage_load;
                        result_valid      <= 1'b0;
                        deadlock          <= 1'b0;
                        iteration_counter <= '0;
                        cycle_counter     <= '0;
                    end
                end
                decoder_stage_pkg::stage_load: begin
                    stage        <= decoder_stage_pkg::stage_check;
                    check_second <= 1'b0;
                end
                decoder_stage_pkg::stage_check: begin
                    check_second <= ~check_second;
                    if (check_second) begin
                        if (!has_odd_clusters) begin
                            stage        <= decoder_stage_pkg::stage_result;
                            result_valid <= 1'b1;
                        end else if (iteration_counter >= iteration_limit) begin
                            stage        <= decoder_stage_pkg::stage_result;
                            result_valid <= 1'b1;
                            deadlock     <= 1'b1;  // still odd after the last allowed growth
                        end else begin
                            stage             <= decoder_stage_pkg::stage_grow;
                            iteration_counter <= iteration_counter + 1'b1;
                        end
                    end
                end
                decoder_stage_pkg::stage_grow: begin
                    stage <= decoder_stage_pkg::stage_merge;
                end
                decoder_stage_pkg::stage_merge: begin
                    // roots have converged once no unit changes in a cycle
                    if (!has_message_flying) begin
                        stage <= decoder_stage_pkg::stage_check;
                    end
                end
                default: begin
                    stage <= decoder_stage_pkg::stage_idle;
                end
            endcase
        end
    end

endmodule

// ==== verilog/decoder_with_stage_controller.sv ====
// union-find decoder top level: the decoding grid driven by the stage controller
// pulse new_round_start with syndromes applied, read results while result_valid is high
`timescale 1ns/1ps

module decoder_with_stage_controller (
    input  logic                                                                    clk,
    input  logic                                                                    rst,
    input  logic                                                                    new_round_start,
    input  logic [code_geometry_pkg::pu_count-1:0]                                  is_error_syndromes,
    output logic [code_geometry_pkg::pu_count*code_geometry_pkg::address_width-1:0] roots,
    output logic                                                                    result_valid,
    output logic [decoder_stage_pkg::iteration_width-1:0]                           iteration_counter,
    output logic [31:0]                                                             cycle_counter,
    output logic                                                                    deadlock
);

    decoder_stage_pkg::stage_t stage;
    logic                      has_message_flying;
    logic                      has_odd_clusters;

    // roots only move in load and merge, so they hold through result
    decoding_grid u_decoding_grid (
        .clk(clk),
        .rst(rst),
        .stage(stage),
        .is_error_syndromes(is_error_syndromes),
        .roots(roots),
        .has_message_flying(has_message_flying),
        .has_odd_clusters(has_odd_clusters)
    );

    decoder_stage_controller u_decoder_stage_controller (
        .clk(clk),
        .rst(rst),
        .new_round_start(new_round_start),
        .has_message_flying(has_message_flying),
        .has_odd_clusters(has_odd_clusters),
        .stage(stage),
        .result_valid(result_valid),
        .iteration_counter(iteration_counter),
        .cycle_counter(cycle_counter),
        .deadlock(deadlock)
    );

endmodule

// ==== tb/tb_decoder.sv ====
// testbench for the union-find decoder top level
// runs directed and random syndrome rounds against an array model of the same rules
`timescale 1ns/1ps

module tb_decoder;

    localparam int aw = code_geometry_pkg::address_width;
    localparam int cols = code_geometry_pkg::grid_cols;
    localparam int rows = code_geometry_pkg::grid_rows;
    localparam int n = code_geometry_pkg::pu_count;
    localparam int weight = int'(code_geometry_pkg::edge_weight);
    localparam int random_rounds = 150;
    localparam int timeout_cycles = 200 * 300;  // rounds times worst-case round length

    logic                                          clk;
    logic                                          rst;
    logic                                          new_round_start;
    logic [n-1:0]                                  is_error_syndromes;
    logic [n*aw-1:0]                               roots;
    logic                                          result_valid;
    logic [decoder_stage_pkg::iteration_width-1:0] iteration_counter;
    logic [31:0]                                   cycle_counter;
    logic                                          deadlock;

    integer seed = 94967;
    int     cycle_count = 0;
    int     error_count = 0;

    // per-unit model state of roots, defects, odd flags and edge counters
    int m_root[n];
    int m_def[n];
    int m_odd[n];
    int h_cnt[n];  // edge to column + 1
    int v_cnt[n];  // edge to row + 1
    int b_cnt[n];
    int m_iter;
    int m_deadlock;
    int m_cycles;

    decoder_with_stage_controller u_dut (
        .clk(clk),
        .rst(rst),
        .new_round_start(new_round_start),
        .is_error_syndromes(is_error_syndromes),
        .roots(roots),
        .result_valid(result_valid),
        .iteration_counter(iteration_counter),
        .cycle_counter(cycle_counter),
        .deadlock(deadlock)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check_equal(input string name, input int got, input int exp);
        assert (got == exp) else begin
            error_count++;
            $display("[FAIL] time %0t: %s expected %0d, got %0d", $time, name, exp, got);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_not_above(input string name, input int got, input int limit);
        assert (got <= limit) else begin
            error_count++;
            $display("[FAIL] time %0t: %s expected at most %0d, got %0d",
                     $time, name, limit, got);
            $display("Simulation failed");
            $fatal(1, "value above limit");
        end
    endtask

    task automatic check_that(input bit cond, input string what);
        assert (cond) else begin
            error_count++;
            $display("error at time %0t: %s", $time, what);
            $display("Simulation failed");
            $fatal(1, "check failed");
        end
    endtask

    function automatic int root_field(input int i);
        return int'(roots[i*aw +: aw]);
    endfunction

    function automatic int saturate(input int x);
        return (x > weight) ? weight : x;
    endfunction

    // a unit is odd when its cluster has odd defect parity and no grown boundary edge
    task automatic find_odd();
        int par;
        int touch;
        for (int i = 0; i < n; i++) begin
            par = 0;
            touch = 0;
            for (int j = 0; j < n; j++) begin
                if (m_root[j] == m_root[i]) begin
                    par = par ^ m_def[j];
                    touch = touch | int'(b_cnt[j] == weight);
                end
            end
            m_odd[i] = par & ~touch & 1;
        end
    endtask

    task automatic grow_edges();
        int i;
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < cols; c++) begin
                i = r * cols + c;
                if (c < cols - 1) h_cnt[i] = saturate(h_cnt[i] + m_odd[i] + m_odd[i+1]);
                if (r < rows - 1) v_cnt[i] = saturate(v_cnt[i] + m_odd[i] + m_odd[i+cols]);
                if (c == 0 || c == cols - 1) b_cnt[i] = saturate(b_cnt[i] + m_odd[i]);
            end
        end
    endtask

    // synchronous min-root passes where the last pass without change also counts as a cycle
    task automatic merge_roots();
        int nxt[n];
        int changed;
        int i;
        changed = 1;
        while (changed != 0) begin
            m_cycles++;
            changed = 0;
            for (int r = 0; r < rows; r++) begin
                for (int c = 0; c < cols; c++) begin
                    i = r * cols + c;
                    nxt[i] = m_root[i];
                    if (c > 0 && h_cnt[i-1] == weight && m_root[i-1] < nxt[i])
                        nxt[i] = m_root[i-1];
                    if (c < cols - 1 && h_cnt[i] == weight && m_root[i+1] < nxt[i])
                        nxt[i] = m_root[i+1];
                    if (r > 0 && v_cnt[i-cols] == weight && m_root[i-cols] < nxt[i])
                        nxt[i] = m_root[i-cols];
                    if (r < rows - 1 && v_cnt[i] == weight && m_root[i+cols] < nxt[i])
                        nxt[i] = m_root[i+cols];
                end
            end
            for (int k = 0; k < n; k++) begin
                if (nxt[k] != m_root[k]) changed = 1;
                m_root[k] = nxt[k];
            end
        end
    endtask

    task automatic run_model(input logic [n-1:0] syn);
        int any;
        int done;
        for (int i = 0; i < n; i++) begin
            m_def[i] = int'(syn[i]);
            m_root[i] = i;
            h_cnt[i] = 0;
            v_cnt[i] = 0;
            b_cnt[i] = 0;
        end
        m_iter = 0;
        m_deadlock = 0;
        m_cycles = 1;  // load
        done = 0;
        while (done == 0) begin
            m_cycles += 2;  // check takes two cycles
            find_odd();
            any = 0;
            for (int i = 0; i < n; i++) any = any | m_odd[i];
            if (any == 0) begin
                done = 1;
            end else if (m_iter >= code_geometry_pkg::max_iterations) begin
                m_deadlock = 1;
                done = 1;
            end else begin
                m_iter++;
                m_cycles++;  // grow
                grow_edges();
                merge_roots();
            end
        end
    endtask

    task automatic start_round(input logic [n-1:0] syn);
        @(posedge clk);
        new_round_start <= 1'b1;
        is_error_syndromes <= syn;
        @(posedge clk);
        new_round_start <= 1'b0;
        @(negedge clk);
        check_equal("result_valid", int'(result_valid), 0);  // cleared by the start
    endtask

    task automatic wait_result();
        while (result_valid !== 1'b1) @(negedge clk);
    endtask

    task automatic check_results();
        string msg;
        // cluster properties first, then the exact model values
        for (int i = 0; i < n; i++) begin
            check_not_above($sformatf("roots[%0d]", i), root_field(i), i);
            for (int j = i + 1; j < n; j++) begin
                if (m_root[j] == m_root[i]) begin
                    msg = $sformatf("units %0d and %0d share a cluster but differ in root", i, j);
                    check_that(root_field(j) == root_field(i), msg);
                end
            end
        end
        check_equal("iteration_counter", int'(iteration_counter), m_iter);
        check_equal("deadlock", int'(deadlock), m_deadlock);
        check_equal("cycle_counter", int'(cycle_counter), m_cycles);
        for (int i = 0; i < n; i++) begin
            check_equal($sformatf("roots[%0d]", i), root_field(i), m_root[i]);
        end
        repeat (3) @(negedge clk);
        check_equal("result_valid", int'(result_valid), 1);
        check_equal("iteration_counter", int'(iteration_counter), m_iter);
        check_equal("cycle_counter", int'(cycle_counter), m_cycles);
        for (int i = 0; i < n; i++) check_equal($sformatf("roots[%0d]", i), root_field(i), m_root[i]);
    endtask

    task automatic run_round(input logic [n-1:0] syn);
        run_model(syn);
        start_round(syn);
        wait_result();
        check_results();
    endtask

    // two adjacent defects give a two-cycle merge and the pulse lands in its second cycle
    task automatic start_during_merge();
        logic [n-1:0] syn;
        syn = 16'h0060;
        run_model(syn);
        start_round(syn);
        while (!(u_dut.stage == decoder_stage_pkg::stage_merge && u_dut.has_message_flying))
            @(negedge clk);
        @(posedge clk);
        new_round_start <= 1'b1;
        @(posedge clk);
        new_round_start <= 1'b0;
        @(negedge clk);
        check_that(u_dut.stage != decoder_stage_pkg::stage_load,
                   "a start pulse during merge restarted the round");
        wait_result();
        check_results();
    endtask

    initial begin
        logic [n-1:0] syn;
        int density;
        rst = 1'b1;
        new_round_start = 1'b0;
        is_error_syndromes = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_equal("result_valid", int'(result_valid), 0);
        check_equal("deadlock", int'(deadlock), 0);
        check_equal("cycle_counter", int'(cycle_counter), 0);
        check_equal("iteration_counter", int'(iteration_counter), 0);
        for (int i = 0; i < n; i++) check_equal($sformatf("roots[%0d]", i), root_field(i), i);

        run_round('0);
        check_equal("iteration_counter", int'(iteration_counter), 0);

        // the boundary edge has one odd end and fills after weight iterations
        run_round(16'h0001);
        check_equal("iteration_counter", int'(iteration_counter), weight);
        check_equal("roots[0]", root_field(0), 0);

        start_during_merge();

        for (int k = 0; k < random_rounds; k++) begin
            density = $random(seed) & 7;
            for (int i = 0; i < n; i++) syn[i] = (($random(seed) & 15) < density);
            run_round(syn);
        end

        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
verilog/code_geometry_pkg.sv
verilog/decoder_stage_pkg.sv
verilog/processing_unit.sv
verilog/edge_tracker.sv
verilog/cluster_tracker.sv
verilog/decoding_grid.sv
verilog/decoder_stage_controller.sv
verilog/decoder_with_stage_controller.sv
tb/tb_decoder.sv

// ==== Makefile ====
# Verilator build and run of the union-find decoder testbench
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_decoder
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= Simulation completed successfully

.PHONY: sim clean

# the run may exit nonzero on failure; the log search decides the status
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
